/* Makefile */
VERILATOR    = verilator
VFLAGS       = --binary --timing --assert
TOP          = hexSpeakTop_tb
FILELIST     = compile.f
BUILD_DIR    = obj_dir
PASS_PATTERN = Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_PATTERN)"

clean:
	rm -rf $(BUILD_DIR)

/* alu.sv */
`timescale 1ns/10ps
`include "hexSpeak_settings.svh"

module alu import hexSpeak_pkg::*; (
	input  aluOp_t                 op,
	input  logic                   selectImm, // Operand B from imm
	input  logic [7:0]             imm,
	input  logic [`DATA_WIDTH-1:0] dataA,
	input  logic [`DATA_WIDTH-1:0] dataB,
	output logic [`DATA_WIDTH-1:0] result
);

	logic [`DATA_WIDTH-1:0] operandB;

	//////////////////////////////
	// Operand select
	//////////////////////////////

	// Immediate is unsigned, zero-extended to the datapath width
	assign operandB = selectImm ? {{(`DATA_WIDTH-8){1'b0}}, imm} : dataB;

	//////////////////////////////
	// Operations
	//////////////////////////////

	// All results wrap at the datapath width
	always_comb begin
		case (op)
			OP_ADDU:  result = dataA + operandB;
			OP_ADDUI: result = dataA + operandB; // Same adder, imm normally selected
			OP_AND:   result = dataA & operandB;
			OP_OR:    result = dataA | operandB;
			OP_XOR:   result = dataA ^ operandB;
			OP_NOT:   result = ~dataA;            // Operand B ignored
			OP_LSHI:  result = dataA << operandB; // Large shift gives zero
			OP_RSHI:  result = dataA >> operandB; // Logical, zero fill
			default:  result = '0;                // Undefined opcode
		endcase
	end

endmodule

/* compile.f */
+incdir+.
hexSpeak_pkg.sv
hexSpeakFsm.sv
registerFile.sv
alu.sv
hexSpeakTop.sv
hexSpeakTop_sva.sv
hexSpeakTop_tb.sv

/* hexSpeakFsm.sv */
`timescale 1ns/10ps
`include "hexSpeak_settings.svh"

module hexSpeakFsm import hexSpeak_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  regIndex_t extInput,     // Register to show once the program is done
	output microOp_t  microOp,      // Step currently being executed
	output logic      sequenceDone  // High in the display state
);

	// Step after the last program step
	localparam logic [4:0] DISPLAY_STEP = 5'(`PROGRAM_LENGTH);

	logic [4:0] step;     // Present state
	logic [4:0] nextStep; // Next state

	//////////////////////////////
	// Step counter
	//////////////////////////////

	// Advance one step per edge, park on the display step
	always_comb begin
		if (step >= DISPLAY_STEP) begin
			nextStep = DISPLAY_STEP; // Saturate
		end else begin
			nextStep = step + 5'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= 5'd0; // Restart the program
		end else begin
			step <= nextStep;
		end
	end

	assign sequenceDone = (step == DISPLAY_STEP); // From the registered state only

	//////////////////////////////
	// Micro-op table
	//////////////////////////////

	// Fields: op, writeEnable, writeReg, readRegA, readRegB, selectImm, imm
	always_comb begin
		case (step)
			// Build 8BAD in r2
			5'd0:  microOp = '{OP_ADDUI, 1'b1, 4'd14, 4'd14, 4'd14, 1'b1, 8'h74}; // r14 = 0074
			5'd1:  microOp = '{OP_NOT,   1'b1, 4'd14, 4'd14, 4'd14, 1'b0, 8'h00}; // r14 = FF8B
			5'd2:  microOp = '{OP_LSHI,  1'b1, 4'd14, 4'd14, 4'd14, 1'b1, 8'h08}; // r14 = 8B00
			5'd3:  microOp = '{OP_ADDUI, 1'b1, 4'd7,  4'd7,  4'd0,  1'b1, 8'h52}; // r7 = 0052
			5'd4:  microOp = '{OP_ADDUI, 1'b1, 4'd0,  4'd0,  4'd0,  1'b1, 8'hFF}; // r0 = 00FF
			5'd5:  microOp = '{OP_XOR,   1'b1, 4'd7,  4'd0,  4'd7,  1'b0, 8'h00}; // r7 = 00AD
			5'd6:  microOp = '{OP_LSHI,  1'b1, 4'd7,  4'd7,  4'd7,  1'b1, 8'h08}; // r7 = AD00
			5'd7:  microOp = '{OP_RSHI,  1'b1, 4'd7,  4'd7,  4'd7,  1'b1, 8'h08}; // Back to 00AD
			5'd8:  microOp = '{OP_ADDU,  1'b1, 4'd2,  4'd14, 4'd7,  1'b0, 8'h00}; // r2 = 8BAD

			// Build F00D in r3
			5'd9:  microOp = '{OP_LSHI,  1'b1, 4'd12, 4'd0,  4'd0,  1'b1, 8'h0C}; // r12 = F000
			5'd10: microOp = '{OP_ADDUI, 1'b1, 4'd13, 4'd13, 4'd13, 1'b1, 8'h0D}; // r13 = 000D
			5'd11: microOp = '{OP_AND,   1'b1, 4'd13, 4'd13, 4'd0,  1'b0, 8'h00}; // Mask with r0
			5'd12: microOp = '{OP_ADDU,  1'b1, 4'd3,  4'd12, 4'd13, 1'b0, 8'h00}; // r3 = F00D

			// Build DEAD in r11, r4 is the zero source
			5'd13: microOp = '{OP_ADDUI, 1'b1, 4'd5,  4'd4,  4'd4,  1'b1, 8'hD0}; // r5 = 00D0
			5'd14: microOp = '{OP_ADDUI, 1'b1, 4'd6,  4'd4,  4'd4,  1'b1, 8'h0E}; // r6 = 000E
			5'd15: microOp = '{OP_OR,    1'b1, 4'd11, 4'd6,  4'd5,  1'b0, 8'h00}; // r11 = 00DE
			5'd16: microOp = '{OP_LSHI,  1'b1, 4'd11, 4'd11, 4'd11, 1'b1, 8'h08}; // r11 = DE00
			5'd17: microOp = '{OP_ADDUI, 1'b1, 4'd8,  4'd4,  4'd4,  1'b1, 8'hAD}; // r8 = 00AD
			5'd18: microOp = '{OP_LSHI,  1'b1, 4'd8,  4'd8,  4'd8,  1'b1, 8'h08}; // r8 = AD00
			5'd19: microOp = '{OP_RSHI,  1'b1, 4'd8,  4'd8,  4'd8,  1'b1, 8'h08}; // Back to 00AD
			5'd20: microOp = '{OP_ADDU,  1'b1, 4'd11, 4'd11, 4'd8,  1'b0, 8'h00}; // r11 = DEAD

			// Build BEEF in r15
			5'd21: microOp = '{OP_ADDUI, 1'b1, 4'd5,  4'd6,  4'd6,  1'b1, 8'hB0}; // r5 = 00BE
			5'd22: microOp = '{OP_LSHI,  1'b1, 4'd5,  4'd5,  4'd5,  1'b1, 8'h08}; // r5 = BE00
			5'd23: microOp = '{OP_LSHI,  1'b1, 4'd6,  4'd6,  4'd6,  1'b1, 8'h04}; // r6 = 00E0
			5'd24: microOp = '{OP_ADDUI, 1'b1, 4'd15, 4'd6,  4'd6,  1'b1, 8'h0F}; // r15 = 00EF
			5'd25: microOp = '{OP_ADDU,  1'b1, 4'd15, 4'd15, 4'd5,  1'b0, 8'h00}; // r15 = BEEF

			// Display state, OR of a register with itself passes it through
			default: begin
				microOp.op          = OP_OR;
				microOp.writeEnable = 1'b0;     // Never write while displaying
				microOp.writeReg    = '0;
				microOp.readRegA    = extInput;
				microOp.readRegB    = extInput;
				microOp.selectImm   = 1'b0;
				microOp.imm         = 8'h00;
			end
		endcase
	end

endmodule

/* hexSpeakTop.sv */
`timescale 1ns/10ps
`include "hexSpeak_settings.svh"

module hexSpeakTop import hexSpeak_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  regIndex_t              extInput,     // Register select in display
	output logic [`DATA_WIDTH-1:0] displayValue, // ALU result, selected register in display
	output logic                   sequenceDone  // Program finished
);

	microOp_t               microOp; // Current step from the sequencer
	logic [`DATA_WIDTH-1:0] dataA;
	logic [`DATA_WIDTH-1:0] dataB;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	hexSpeakFsm i_hexSpeakFsm (
		.clk          (clk),
		.reset        (reset),
		.extInput     (extInput),
		.microOp      (microOp),
		.sequenceDone (sequenceDone)
	);

	//////////////////////////////
	// Datapath
	//////////////////////////////

	registerFile i_registerFile (
		.clk         (clk),
		.reset       (reset),
		.readRegA    (microOp.readRegA),
		.readRegB    (microOp.readRegB),
		.dataA       (dataA),
		.dataB       (dataB),
		.writeEnable (microOp.writeEnable),
		.writeReg    (microOp.writeReg),
		.writeData   (displayValue)         // Result loops back for the write
	);

	alu i_alu (
		.op        (microOp.op),
		.selectImm (microOp.selectImm),
		.imm       (microOp.imm),
		.dataA     (dataA),
		.dataB     (dataB),
		.result    (displayValue)
	);

endmodule

/* hexSpeakTop_sva.sv */
`timescale 1ns/10ps
`include "hexSpeak_settings.svh"

module hexSpeakTop_sva import hexSpeak_pkg::*; (
	input logic                   clk,
	input logic                   reset,
	input regIndex_t              extInput,
	input logic [`DATA_WIDTH-1:0] displayValue,
	input logic                   sequenceDone
);

	//////////////////////////////
	// Sequencer state
	//////////////////////////////

	// Reset always sends the sequencer back to step 0
	doneClearedByReset: assert property (@(posedge clk) reset |=> !sequenceDone)
		else $error("sequenceDone still high one cycle after reset");

	// Once in display, only a reset leaves it
	doneNeverFalls: assert property (@(posedge clk) disable iff (reset)
		sequenceDone |=> (sequenceDone || reset))
		else $error("sequenceDone fell without a reset");

	//////////////////////////////
	// Display state
	//////////////////////////////

	// Nothing is written in display, so same select gives same value
	displayHolds: assert property (@(posedge clk) disable iff (reset)
		(sequenceDone && $past(sequenceDone) && $stable(extInput)) |-> $stable(displayValue))
		else $error("displayValue changed while extInput was held in display");

endmodule

bind hexSpeakTop hexSpeakTop_sva i_hexSpeakTop_sva (
	.clk          (clk),
	.reset        (reset),
	.extInput     (extInput),
	.displayValue (displayValue),
	.sequenceDone (sequenceDone)
);

/* hexSpeakTop_tb.sv */
`timescale 1ns/10ps
`include "hexSpeak_settings.svh"

module hexSpeakTop_tb import hexSpeak_pkg::*; ();

	localparam int CLOCK_PERIOD    = 40;  // ns
	localparam int RESET_CYCLES    = 16;
	localparam int WATCHDOG_CYCLES = 600; // Two program runs plus all sweeps with margin

	logic                   clk;
	logic                   reset;
	regIndex_t              extInput;
	logic [`DATA_WIDTH-1:0] displayValue;
	logic                   sequenceDone;

	hexSpeakTop i_hexSpeakTop (
		.clk          (clk),
		.reset        (reset),
		.extInput     (extInput),
		.displayValue (displayValue),
		.sequenceDone (sequenceDone)
	);

	always #(CLOCK_PERIOD / 2) clk = ~clk;

	//////////////////////////////
	// Expected results
	//////////////////////////////

	// Register contents once the program has finished
	function automatic logic [`DATA_WIDTH-1:0] expectedValue(input regIndex_t r);
		case (r)
			4'd0:    return 16'h00FF;
			4'd2:    return 16'h8BAD;
			4'd3:    return 16'hF00D;
			4'd5:    return 16'hBE00;
			4'd6:    return 16'h00E0;
			4'd7:    return 16'h00AD;
			4'd8:    return 16'h00AD;
			4'd11:   return 16'hDEAD;
			4'd12:   return 16'hF000;
			4'd13:   return 16'h000D;
			4'd14:   return 16'h8B00;
			4'd15:   return 16'hBEEF;
			default: return 16'h0000; // r1, r4, r9 and r10 never written
		endcase
	endfunction

	task automatic checkValue(input string testName, input logic [`DATA_WIDTH-1:0] expected,
			input logic [`DATA_WIDTH-1:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s: expected %h, actual %h", testName, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("[FAIL] %s: expected %b, actual %b", testName, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Flag mismatch");
		end
	endtask

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	// Hold reset for the full count while done stays low
	task automatic applyReset();
		@(posedge clk);
		#2 reset = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#2;
			checkFlag("doneLowInReset", 1'b0, sequenceDone);
		end
		reset = 1'b0; // Released 2 ns after the last reset edge
	endtask

	// Step 0 adds 0x74 to a cleared r14, then done rises on edge 26 exactly
	task automatic runProgram(input string testName);
		#1;
		checkValue(testName, 16'h0074, displayValue); // Would be 8B74 if r14 kept old value
		for (int k = 1; k <= `PROGRAM_LENGTH; k++) begin
			@(posedge clk);
			#2;
			checkFlag(testName, (k == `PROGRAM_LENGTH), sequenceDone);
		end
	endtask

	task automatic selectAndCheck(input string testName, input regIndex_t sel);
		@(posedge clk);
		#2 extInput = sel;
		@(negedge clk); // Sampled mid-cycle once the combinational path has settled
		checkValue(testName, expectedValue(sel), displayValue);
	endtask

	task automatic sweepRegisters(input string testName);
		for (int sel = 0; sel < `REG_COUNT; sel++) begin
			selectAndCheck(testName, regIndex_t'(sel));
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;
		extInput = '0;
		void'($urandom(70));

		applyReset();
		runProgram("doneTimingFirstRun");

		selectAndCheck("hexWordR2", 4'd2);   // 8BAD
		selectAndCheck("hexWordR3", 4'd3);   // F00D
		selectAndCheck("hexWordR11", 4'd11); // DEAD
		selectAndCheck("hexWordR15", 4'd15); // BEEF

		// Same select held over several edges so the value must not move
		repeat (4) begin
			selectAndCheck("heldDisplay", 4'd15);
		end

		sweepRegisters("fullTable");

		repeat (64) begin
			selectAndCheck("randomDisplay", regIndex_t'($urandom_range(15, 0)));
		end

		// Reset in the middle of display restarts the program
		@(posedge clk);
		#2 extInput = 4'd2;
		applyReset();
		runProgram("restartAfterReset");
		sweepRegisters("fullTableAfterRestart");

		$display("Result: PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* hexSpeak_pkg.sv */
`include "hexSpeak_settings.svh"

package hexSpeak_pkg;

	//////////////////////////////
	// ALU opcodes
	//////////////////////////////

	// 8-bit encodings kept from the original instruction set
	typedef enum logic [7:0] {
		OP_AND   = 8'b0000_0001, // Bitwise AND
		OP_OR    = 8'b0000_0010, // Bitwise OR, also used as pass-through
		OP_XOR   = 8'b0000_0011, // Bitwise XOR
		OP_ADDU  = 8'b0000_0110, // Unsigned add, register operands
		OP_NOT   = 8'b0000_1111, // Invert operand A
		OP_ADDUI = 8'b0110_0000, // Unsigned add with immediate
		OP_LSHI  = 8'b1000_0000, // Logical shift left
		OP_RSHI  = 8'b1000_0001  // Logical shift right
	} aluOp_t;

	// Register number
	typedef logic [$clog2(`REG_COUNT)-1:0] regIndex_t;

	//////////////////////////////
	// Micro-operation
	//////////////////////////////

	// One sequencer step, drives register file and ALU together
	typedef struct packed {
		aluOp_t    op;          // ALU operation
		logic      writeEnable; // Write result back this cycle
		regIndex_t writeReg;    // Destination register
		regIndex_t readRegA;    // Operand A source
		regIndex_t readRegB;    // Operand B source
		logic      selectImm;   // Operand B from imm instead of readRegB
		logic [7:0] imm;        // Unsigned immediate, zero-extended in ALU
	} microOp_t;

endpackage

/* hexSpeak_settings.svh */
`ifndef HEXSPEAK_SETTINGS_SVH
`define HEXSPEAK_SETTINGS_SVH

//////////////////////////////
// Datapath sizing
//////////////////////////////

// Width of every register and of the ALU
`define DATA_WIDTH 16

// Register file depth, sets the register index width
`define REG_COUNT 16

//////////////////////////////
// Sequencer
//////////////////////////////

// Steps before the display state is reached
`define PROGRAM_LENGTH 26 // Display step index is this value

`endif

/* registerFile.sv */
`timescale 1ns/10ps
`include "hexSpeak_settings.svh"

module registerFile import hexSpeak_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,       // Clears every register
	input  regIndex_t              readRegA,
	input  regIndex_t              readRegB,
	output logic [`DATA_WIDTH-1:0] dataA,       // Combinational read port A
	output logic [`DATA_WIDTH-1:0] dataB,       // Combinational read port B
	input  logic                   writeEnable,
	input  regIndex_t              writeReg,
	input  logic [`DATA_WIDTH-1:0] writeData
);

	logic [`DATA_WIDTH-1:0] registers [`REG_COUNT];

	//////////////////////////////
	// Write port
	//////////////////////////////

	// Program depends on all registers starting at zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				registers[i] <= '0;
			end
		end else if (writeEnable) begin
			registers[writeReg] <= writeData; // Seen by reads after this edge
		end
	end

	// Read ports, no bypass of a write in the same cycle
	assign dataA = registers[readRegA];
	assign dataB = registers[readRegB];

endmodule
